// File: logic/fpu_consts.svh
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// binary32 field widths
`define FP_EXP_W 8
`define FP_SIG_W 23
`define FP_BIAS 127

// all-ones exponent marks infinity and NaN
`define FP_INF_EXP 8'hff

// canonical quiet NaN returned for every NaN result
`define FP_QNAN 32'h7fc00000

// largest finite magnitude, sign bit excluded
`define FP_POS_MAX 31'h7f7fffff

// cycles from i_valid to o_valid
`define FP_MUL_LAT 3

`endif

// File: logic/fpu_pkg.sv
`default_nettype none

`include "fpu_consts.svh"

package fpu_pkg;

    typedef logic [31:0]                    fp32_t;
    typedef logic [`FP_EXP_W-1:0]           fp_exp_t;
    // significand with the hidden bit on top
    typedef logic [`FP_SIG_W:0]             fp_sig_t;
    typedef logic [2*`FP_SIG_W+1:0]         fp_prod_t;
    // wide enough for exp_a + exp_b - bias and a full normalize shift
    typedef logic signed [`FP_EXP_W+1:0]    fp_wexp_t;
    typedef logic [4:0]                     fp_rm_t;
    typedef logic [3:0]                     fp_flags_t;
    typedef logic [5:0]                     fp_class_t;

    // rounding mode bits, lowest set bit wins
    localparam int RM_RNE = 0;
    localparam int RM_RNA = 1;
    localparam int RM_RTP = 2;
    localparam int RM_RTN = 3;
    localparam int RM_RTZ = 4;

    // flag bits, NV on top
    localparam int FLG_NV = 3;
    localparam int FLG_OF = 2;
    localparam int FLG_UF = 1;
    localparam int FLG_NX = 0;

    // operand class bits
    localparam int CLS_ZERO = 5;
    localparam int CLS_SUB  = 4;
    localparam int CLS_NORM = 3;
    localparam int CLS_INF  = 2;
    localparam int CLS_QNAN = 1;
    localparam int CLS_SNAN = 0;

endpackage

`default_nettype wire

// File: logic/fp_operand_unpack.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fp_operand_unpack (
    input  wire logic               i_clk,
    input  wire logic               i_rst,
    input  wire logic               i_valid,
    input  wire fpu_pkg::fp32_t     i_a,
    input  wire fpu_pkg::fp32_t     i_b,
    input  wire fpu_pkg::fp_rm_t    i_rm,
    output logic                    o_valid,
    output logic                    o_sign_a,
    output logic                    o_sign_b,
    output fpu_pkg::fp_exp_t        o_exp_a,
    output fpu_pkg::fp_exp_t        o_exp_b,
    output fpu_pkg::fp_sig_t        o_sig_a,
    output fpu_pkg::fp_sig_t        o_sig_b,
    output fpu_pkg::fp_class_t      o_class_a,
    output fpu_pkg::fp_class_t      o_class_b,
    output fpu_pkg::fp_rm_t         o_rm
);

    function automatic fpu_pkg::fp_class_t classify(input fpu_pkg::fp32_t x);
        fpu_pkg::fp_exp_t       e;
        logic [`FP_SIG_W-1:0]   f;
        fpu_pkg::fp_class_t     c;
        e = x[30:`FP_SIG_W];
        f = x[`FP_SIG_W-1:0];
        c = '0;
        if (e == `FP_INF_EXP) begin
            if (f == '0)
                c[fpu_pkg::CLS_INF] = 1'b1;
            // top fraction bit separates quiet from signaling
            else if (f[`FP_SIG_W-1])
                c[fpu_pkg::CLS_QNAN] = 1'b1;
            else
                c[fpu_pkg::CLS_SNAN] = 1'b1;
        end else if (e == '0) begin
            if (f == '0)
                c[fpu_pkg::CLS_ZERO] = 1'b1;
            else
                c[fpu_pkg::CLS_SUB] = 1'b1;
        end else begin
            c[fpu_pkg::CLS_NORM] = 1'b1;
        end
        return c;
    endfunction

    // subnormals share the scale of exponent 1, only the hidden bit differs
    function automatic fpu_pkg::fp_exp_t eff_exp(input fpu_pkg::fp32_t x);
        return (x[30:`FP_SIG_W] == '0) ? fpu_pkg::fp_exp_t'(1) : x[30:`FP_SIG_W];
    endfunction

    function automatic fpu_pkg::fp_sig_t eff_sig(input fpu_pkg::fp32_t x);
        return {x[30:`FP_SIG_W] != '0, x[`FP_SIG_W-1:0]};
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rst)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_sign_a  <= i_a[31];
            o_sign_b  <= i_b[31];
            o_exp_a   <= eff_exp(i_a);
            o_exp_b   <= eff_exp(i_b);
            o_sig_a   <= eff_sig(i_a);
            o_sig_b   <= eff_sig(i_b);
            o_class_a <= classify(i_a);
            o_class_b <= classify(i_b);
            o_rm      <= i_rm;
        end
    end

    // downstream special-case decode relies on exactly one class per operand
    a_class_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        o_valid |-> $onehot(o_class_a) && $onehot(o_class_b));

endmodule

`default_nettype wire

// File: logic/fp_mul_round.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fp_mul_round (
    input  wire logic               i_clk,
    input  wire logic               i_rst,
    input  wire logic               i_valid,
    input  wire logic               i_sign_a,
    input  wire logic               i_sign_b,
    input  wire fpu_pkg::fp_exp_t   i_exp_a,
    input  wire fpu_pkg::fp_exp_t   i_exp_b,
    input  wire fpu_pkg::fp_sig_t   i_sig_a,
    input  wire fpu_pkg::fp_sig_t   i_sig_b,
    input  wire fpu_pkg::fp_class_t i_class_a,
    input  wire fpu_pkg::fp_class_t i_class_b,
    input  wire fpu_pkg::fp_rm_t    i_rm,
    output logic                    o_valid,
    output fpu_pkg::fp32_t          o_result,
    output fpu_pkg::fp_flags_t      o_flags,
    output logic                    o_nan_in,
    output fpu_pkg::fp_rm_t         o_rm
);

    function automatic logic [5:0] lzc48(input fpu_pkg::fp_prod_t p);
        logic [5:0] n;
        n = 6'd48;
        // highest set bit is found last and wins
        for (int i = 0; i < 48; i++) begin
            if (p[i])
                n = 6'(47 - i);
        end
        return n;
    endfunction

    logic               nan_a, nan_b, inf_a, inf_b, zero_a, zero_b;
    logic               any_nan, any_snan, inf_x_zero;
    logic               res_sign;
    fpu_pkg::fp32_t     spec_res;

    logic               r_valid;
    logic               r_sign;
    fpu_pkg::fp_prod_t  r_prod;
    fpu_pkg::fp_wexp_t  r_wexp;
    fpu_pkg::fp_rm_t    r_rm;
    logic               r_special;
    fpu_pkg::fp32_t     r_spec_res;
    logic               r_spec_nv;
    logic               r_nan_in;

    // special operand decode ahead of the stage 2 register
    always_comb begin
        nan_a      = i_class_a[fpu_pkg::CLS_QNAN] | i_class_a[fpu_pkg::CLS_SNAN];
        nan_b      = i_class_b[fpu_pkg::CLS_QNAN] | i_class_b[fpu_pkg::CLS_SNAN];
        inf_a      = i_class_a[fpu_pkg::CLS_INF];
        inf_b      = i_class_b[fpu_pkg::CLS_INF];
        zero_a     = i_class_a[fpu_pkg::CLS_ZERO];
        zero_b     = i_class_b[fpu_pkg::CLS_ZERO];
        any_nan    = nan_a | nan_b;
        any_snan   = i_class_a[fpu_pkg::CLS_SNAN] | i_class_b[fpu_pkg::CLS_SNAN];
        inf_x_zero = (inf_a & zero_b) | (zero_a & inf_b);
        res_sign   = i_sign_a ^ i_sign_b;
        if (any_nan || inf_x_zero)
            spec_res = `FP_QNAN;
        else if (inf_a || inf_b)
            spec_res = {res_sign, `FP_INF_EXP, {`FP_SIG_W{1'b0}}};
        else
            spec_res = {res_sign, 31'b0};
    end

    always_ff @(posedge i_clk) begin
        if (i_rst)
            r_valid <= 1'b0;
        else
            r_valid <= i_valid;
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            r_sign     <= res_sign;
            r_prod     <= i_sig_a * i_sig_b;
            r_wexp     <= fpu_pkg::fp_wexp_t'({2'b00, i_exp_a})
                        + fpu_pkg::fp_wexp_t'({2'b00, i_exp_b})
                        - fpu_pkg::fp_wexp_t'(`FP_BIAS);
            r_rm       <= i_rm;
            r_special  <= any_nan | inf_a | inf_b | zero_a | zero_b;
            r_spec_res <= spec_res;
            r_spec_nv  <= any_snan | inf_x_zero;
            r_nan_in   <= any_nan;
        end
    end

    logic [5:0]         lz;
    fpu_pkg::fp_wexp_t  e_norm;
    fpu_pkg::fp_wexp_t  sh_full;
    logic [5:0]         sh;
    fpu_pkg::fp_prod_t  norm_m;
    logic [95:0]        shifted;
    fpu_pkg::fp_sig_t   sig24;
    logic               tiny, guard, sticky, inexact;
    logic               round_up, to_inf, ovf;
    fpu_pkg::fp_exp_t   exp_f;
    logic [30:0]        rnd_mag;
    logic [30:0]        ovf_mag;

    always_comb begin
        // product msb at bit 47 means biased exponent wexp + 1
        lz      = lzc48(r_prod);
        e_norm  = r_wexp + fpu_pkg::fp_wexp_t'(1) - fpu_pkg::fp_wexp_t'({4'b0000, lz});
        norm_m  = r_prod << lz;
        tiny    = e_norm < fpu_pkg::fp_wexp_t'(1);
        sh_full = fpu_pkg::fp_wexp_t'(1) - e_norm;
        if (!tiny)
            sh = 6'd0;
        else if (sh_full > fpu_pkg::fp_wexp_t'(48))
            sh = 6'd48;
        else
            sh = sh_full[5:0];

        // denormalize, low half collects the bits shifted out
        shifted = {norm_m, 48'b0} >> sh;
        sig24   = shifted[95:72];
        guard   = shifted[71];
        sticky  = (|shifted[70:48]) | (|shifted[47:0]);
        inexact = guard | sticky;
        exp_f   = tiny ? '0 : e_norm[`FP_EXP_W-1:0];

        if (r_rm[fpu_pkg::RM_RNE]) begin
            round_up = guard & (sticky | sig24[0]);
            to_inf   = 1'b1;
        end else if (r_rm[fpu_pkg::RM_RNA]) begin
            round_up = guard;
            to_inf   = 1'b1;
        end else if (r_rm[fpu_pkg::RM_RTP]) begin
            round_up = inexact & ~r_sign;
            to_inf   = ~r_sign;
        end else if (r_rm[fpu_pkg::RM_RTN]) begin
            round_up = inexact & r_sign;
            to_inf   = r_sign;
        end else begin
            round_up = 1'b0;
            to_inf   = 1'b0;
        end

        // a carry out of the fraction bumps the exponent field directly
        rnd_mag = {exp_f, sig24[`FP_SIG_W-1:0]} + 31'(round_up);
        ovf     = (e_norm > fpu_pkg::fp_wexp_t'(254))
                | (rnd_mag[30:`FP_SIG_W] == `FP_INF_EXP);
        ovf_mag = to_inf ? {`FP_INF_EXP, {`FP_SIG_W{1'b0}}} : `FP_POS_MAX;

        o_flags = '0;
        if (r_special) begin
            o_result                = r_spec_res;
            o_flags[fpu_pkg::FLG_NV] = r_spec_nv;
        end else if (ovf) begin
            o_result                = {r_sign, ovf_mag};
            o_flags[fpu_pkg::FLG_OF] = 1'b1;
            o_flags[fpu_pkg::FLG_NX] = 1'b1;
        end else begin
            o_result                = {r_sign, rnd_mag};
            // tininess is judged before rounding
            o_flags[fpu_pkg::FLG_UF] = tiny & inexact;
            o_flags[fpu_pkg::FLG_NX] = inexact;
        end
    end

    assign o_valid  = r_valid;
    assign o_nan_in = r_nan_in;
    assign o_rm     = r_rm;

    a_of_inexact: assert property (@(posedge i_clk) disable iff (i_rst)
        o_valid && o_flags[fpu_pkg::FLG_OF] |-> o_flags[fpu_pkg::FLG_NX]);

    a_uf_inexact: assert property (@(posedge i_clk) disable iff (i_rst)
        o_valid && o_flags[fpu_pkg::FLG_UF] |-> o_flags[fpu_pkg::FLG_NX]);

endmodule

`default_nettype wire

// File: logic/fp_flag_audit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fp_flag_audit (
    input  wire logic               i_clk,
    input  wire logic               i_rst,
    input  wire logic               i_valid,
    input  wire fpu_pkg::fp32_t     i_result,
    input  wire fpu_pkg::fp_flags_t i_flags,
    input  wire logic               i_nan_in,
    input  wire fpu_pkg::fp_rm_t    i_rm,
    input  wire logic               i_flags_clr,
    output logic                    o_valid,
    output fpu_pkg::fp32_t          o_result,
    output fpu_pkg::fp_flags_t      o_flags,
    output fpu_pkg::fp_flags_t      o_fflags,
    output logic                    o_audit_err
);

    fpu_pkg::fp_exp_t       res_exp;
    logic [`FP_SIG_W-1:0]   res_frac;
    logic                   res_sign, res_nan, res_qnan, res_inf;
    logic                   res_zero, res_sub, res_max, res_min_norm;
    logic                   nv, of, uf, nx;
    logic                   ovf_ok;
    logic                   audit_fail;

    always_comb begin
        res_sign     = i_result[31];
        res_exp      = i_result[30:`FP_SIG_W];
        res_frac     = i_result[`FP_SIG_W-1:0];
        res_nan      = (res_exp == `FP_INF_EXP) && (res_frac != '0);
        res_qnan     = res_nan && res_frac[`FP_SIG_W-1];
        res_inf      = (res_exp == `FP_INF_EXP) && (res_frac == '0);
        res_zero     = i_result[30:0] == '0;
        res_sub      = (res_exp == '0) && (res_frac != '0);
        res_max      = i_result[30:0] == `FP_POS_MAX;
        // a tiny value may round up into the smallest normal and still be UF
        res_min_norm = i_result[30:0] == 31'h00800000;

        nv = i_flags[fpu_pkg::FLG_NV];
        of = i_flags[fpu_pkg::FLG_OF];
        uf = i_flags[fpu_pkg::FLG_UF];
        nx = i_flags[fpu_pkg::FLG_NX];

        // overflow lands on infinity or max depending on mode and sign
        casez (i_rm)
            5'b????1,
            5'b???10: ovf_ok = res_inf;
            5'b??100: ovf_ok = res_sign ? res_max : res_inf;
            5'b?1000: ovf_ok = res_sign ? res_inf : res_max;
            default:  ovf_ok = res_max;
        endcase

        audit_fail = 1'b0;
        if (i_nan_in && (!res_nan || of || uf || nx))
            audit_fail = 1'b1;
        if (nv && !res_qnan)
            audit_fail = 1'b1;
        if ((of || uf) && !nx)
            audit_fail = 1'b1;
        if (uf && !(res_sub || res_zero || res_min_norm))
            audit_fail = 1'b1;
        // infinities and subnormals are exact unless OF or UF explains it
        if (res_inf && !of && nx)
            audit_fail = 1'b1;
        if (res_sub && !uf && nx)
            audit_fail = 1'b1;
        if (of && !ovf_ok)
            audit_fail = 1'b1;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid     <= 1'b0;
            o_fflags    <= '0;
            o_audit_err <= 1'b0;
        end else begin
            o_valid <= i_valid;
            // a clear in the same cycle as a result keeps that result's flags
            if (i_flags_clr)
                o_fflags <= i_valid ? i_flags : '0;
            else if (i_valid)
                o_fflags <= o_fflags | i_flags;
            if (i_valid && audit_fail)
                o_audit_err <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_result <= i_result;
            o_flags  <= i_flags;
        end
    end

    a_err_sticky: assert property (@(posedge i_clk)
        $past(o_audit_err) && !$past(i_rst) |-> o_audit_err);

endmodule

`default_nettype wire

// File: logic/fp_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fp_mul_unit (
    input  wire logic               i_clk,
    input  wire logic               i_rst,
    input  wire logic               i_valid,
    input  wire fpu_pkg::fp32_t     i_a,
    input  wire fpu_pkg::fp32_t     i_b,
    input  wire fpu_pkg::fp_rm_t    i_rm,
    input  wire logic               i_flags_clr,
    output logic                    o_valid,
    output fpu_pkg::fp32_t          o_result,
    output fpu_pkg::fp_flags_t      o_flags,
    output fpu_pkg::fp_flags_t      o_fflags,
    output logic                    o_audit_err
);

    // stage 1 unpacked operands
    logic                   s1_valid;
    logic                   s1_sign_a, s1_sign_b;
    fpu_pkg::fp_exp_t       s1_exp_a, s1_exp_b;
    fpu_pkg::fp_sig_t       s1_sig_a, s1_sig_b;
    fpu_pkg::fp_class_t     s1_class_a, s1_class_b;
    fpu_pkg::fp_rm_t        s1_rm;

    // stage 2 rounded result
    logic                   s2_valid;
    fpu_pkg::fp32_t         s2_result;
    fpu_pkg::fp_flags_t     s2_flags;
    logic                   s2_nan_in;
    fpu_pkg::fp_rm_t        s2_rm;

    fp_operand_unpack u_unpack (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_valid   (i_valid),
        .i_a       (i_a),
        .i_b       (i_b),
        .i_rm      (i_rm),
        .o_valid   (s1_valid),
        .o_sign_a  (s1_sign_a),
        .o_sign_b  (s1_sign_b),
        .o_exp_a   (s1_exp_a),
        .o_exp_b   (s1_exp_b),
        .o_sig_a   (s1_sig_a),
        .o_sig_b   (s1_sig_b),
        .o_class_a (s1_class_a),
        .o_class_b (s1_class_b),
        .o_rm      (s1_rm)
    );

    fp_mul_round u_mul_round (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_valid   (s1_valid),
        .i_sign_a  (s1_sign_a),
        .i_sign_b  (s1_sign_b),
        .i_exp_a   (s1_exp_a),
        .i_exp_b   (s1_exp_b),
        .i_sig_a   (s1_sig_a),
        .i_sig_b   (s1_sig_b),
        .i_class_a (s1_class_a),
        .i_class_b (s1_class_b),
        .i_rm      (s1_rm),
        .o_valid   (s2_valid),
        .o_result  (s2_result),
        .o_flags   (s2_flags),
        .o_nan_in  (s2_nan_in),
        .o_rm      (s2_rm)
    );

    fp_flag_audit u_audit (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (s2_valid),
        .i_result    (s2_result),
        .i_flags     (s2_flags),
        .i_nan_in    (s2_nan_in),
        .i_rm        (s2_rm),
        .i_flags_clr (i_flags_clr),
        .o_valid     (o_valid),
        .o_result    (o_result),
        .o_flags     (o_flags),
        .o_fflags    (o_fflags),
        .o_audit_err (o_audit_err)
    );

endmodule

`default_nettype wire

// File: verif/fp_mul_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module fp_mul_checker (
    input  wire logic               i_clk,
    input  wire logic               i_rst,
    input  wire logic               i_valid,
    input  wire fpu_pkg::fp32_t     i_a,
    input  wire fpu_pkg::fp32_t     i_b,
    input  wire fpu_pkg::fp_rm_t    i_rm,
    input  wire logic               i_flags_clr,
    input  wire logic               i_out_valid,
    input  wire fpu_pkg::fp32_t     i_result,
    input  wire fpu_pkg::fp_flags_t i_flags,
    input  wire fpu_pkg::fp_flags_t i_fflags,
    input  wire logic               i_audit_err,
    output int                      o_mismatch_cnt,
    output int                      o_fail_cnt,
    output int                      o_checked
);

    // exact product of the integer significands rounded once at the end
    function automatic logic [35:0] ref_fmul(input fpu_pkg::fp32_t a, input fpu_pkg::fp32_t b,
                                             input fpu_pkg::fp_rm_t rm);
        logic               s, a_nan, b_nan, a_snan, b_snan, a_inf, b_inf, a_zero, b_zero;
        logic               inexact, tiny, up, to_inf;
        logic [63:0]        ma, mb, p, sig, rem, half;
        int                 ea, eb, e, msb, q, sh, bexp, mode;
        fpu_pkg::fp_flags_t fl;
        ea     = a[30:23];
        eb     = b[30:23];
        s      = a[31] ^ b[31];
        a_nan  = (ea == 255) && (a[22:0] != 0);
        b_nan  = (eb == 255) && (b[22:0] != 0);
        a_snan = a_nan && !a[22];
        b_snan = b_nan && !b[22];
        a_inf  = (ea == 255) && (a[22:0] == 0);
        b_inf  = (eb == 255) && (b[22:0] == 0);
        a_zero = a[30:0] == 0;
        b_zero = b[30:0] == 0;
        if (a_nan || b_nan)
            return {(a_snan || b_snan) ? 4'b1000 : 4'b0000, `FP_QNAN};
        if ((a_inf && b_zero) || (a_zero && b_inf))
            return {4'b1000, `FP_QNAN};
        if (a_inf || b_inf)
            return {4'b0000, s, 8'hff, 23'b0};
        if (a_zero || b_zero)
            return {4'b0000, s, 31'b0};
        ma = {40'b0, ea != 0, a[22:0]};
        mb = {40'b0, eb != 0, b[22:0]};
        if (ea == 0)
            ea = 1;
        if (eb == 0)
            eb = 1;
        // value is p * 2^e
        p   = ma * mb;
        e   = ea + eb - 254 - 46;
        msb = 0;
        for (int i = 0; i < 48; i++) begin
            if (p[i])
                msb = i;
        end
        tiny = (msb + e + 127) < 1;
        // q is the weight of the last kept bit
        q = msb + e - 23;
        if (q < -149)
            q = -149;
        sh = q - e;
        if (sh <= 0) begin
            sig  = p << (-sh);
            rem  = 0;
            half = 1;
        end else if (sh > 60) begin
            sig  = 0;
            rem  = 1;
            half = 64'h4000_0000_0000_0000;
        end else begin
            sig  = p >> sh;
            rem  = p & ((64'd1 << sh) - 1);
            half = 64'd1 << (sh - 1);
        end
        inexact = rem != 0;
        mode = 4;
        for (int i = 4; i >= 0; i--) begin
            if (rm[i])
                mode = i;
        end
        case (mode)
            0:       up = (rem > half) || ((rem == half) && sig[0]);
            1:       up = rem >= half;
            2:       up = inexact && !s;
            3:       up = inexact && s;
            default: up = 1'b0;
        endcase
        to_inf = (mode < 2) || (mode == 2 && !s) || (mode == 3 && s);
        if (up)
            sig = sig + 1;
        if (sig == (64'd1 << 24)) begin
            sig = sig >> 1;
            q   = q + 1;
        end
        bexp = (sig >= (64'd1 << 23)) ? q + 150 : 0;
        if (bexp >= 255)
            return {4'b0101, s, to_inf ? {8'hff, 23'b0} : `FP_POS_MAX};
        fl = {2'b00, tiny && inexact, inexact};
        return {fl, s, bexp[7:0], sig[22:0]};
    endfunction

    fpu_pkg::fp32_t     exp_res_q[$];
    fpu_pkg::fp_flags_t exp_flg_q[$];
    int                 exp_cyc_q[$];
    int                 cycle = 0;
    logic               rst_prev = 1'b1;
    logic               clr_prev = 1'b0;
    logic               audit_seen = 1'b0;
    logic [35:0]        expv;
    fpu_pkg::fp32_t     res_exp;
    fpu_pkg::fp_flags_t flg_exp;
    fpu_pkg::fp_flags_t sticky_model = '0;
    int                 cyc_in;

    initial begin
        o_mismatch_cnt = 0;
        o_fail_cnt     = 0;
        o_checked      = 0;
    end

    // sample the inputs the DUT sees on this edge
    always @(posedge i_clk) begin
        cycle    = cycle + 1;
        rst_prev = i_rst;
        clr_prev = i_flags_clr;
        if (!i_rst && i_valid) begin
            expv = ref_fmul(i_a, i_b, i_rm);
            exp_res_q.push_back(expv[31:0]);
            exp_flg_q.push_back(expv[35:32]);
            // the operation was driven on the previous edge
            exp_cyc_q.push_back(cycle - 1);
        end
    end

    // outputs are settled half a period after the edge
    always @(negedge i_clk) begin
        if (rst_prev) begin
            sticky_model = '0;
        end else begin
            flg_exp = '0;
            if (i_out_valid) begin
                if (exp_res_q.size() == 0) begin
                    o_fail_cnt++;
                    $display("a result appeared at %0t with no operation in flight", $time);
                end else begin
                    res_exp = exp_res_q.pop_front();
                    flg_exp = exp_flg_q.pop_front();
                    cyc_in  = exp_cyc_q.pop_front();
                    if (cycle != cyc_in + `FP_MUL_LAT) begin
                        o_fail_cnt++;
                        $display("result at %0t came %0d cycles after its input, not %0d",
                                 $time, cycle - cyc_in, `FP_MUL_LAT);
                    end
                    if (i_result !== res_exp) begin
                        o_mismatch_cnt++;
                        $display("mismatch at %0t: o_result got %h expected %h",
                                 $time, i_result, res_exp);
                    end
                    if (i_flags !== flg_exp) begin
                        o_mismatch_cnt++;
                        $display("mismatch at %0t: o_flags got %b expected %b",
                                 $time, i_flags, flg_exp);
                    end
                    o_checked++;
                end
            end
            // a clear on the result's own edge keeps that result's flags
            if (clr_prev)
                sticky_model = flg_exp;
            else
                sticky_model = sticky_model | flg_exp;
            if (i_fflags !== sticky_model) begin
                o_mismatch_cnt++;
                $display("mismatch at %0t: o_fflags got %b expected %b",
                         $time, i_fflags, sticky_model);
            end
            if (i_audit_err !== 1'b0 && !audit_seen) begin
                audit_seen = 1'b1;
                o_fail_cnt++;
                $display("the audit block raised its error flag at %0t", $time);
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_fp_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_consts.svh"

module tb_fp_mul_unit;

    localparam int N_PAIRS    = 13;
    localparam int N_RAND     = 2000;
    localparam int RST_CYCLES = 8;
    localparam int MAX_GAP    = 2;
    localparam int TIMEOUT    = (N_PAIRS * 5 + N_RAND) * (1 + MAX_GAP) + RST_CYCLES + 100;

    logic                   i_clk;
    logic                   i_rst;
    logic                   i_valid;
    fpu_pkg::fp32_t         i_a;
    fpu_pkg::fp32_t         i_b;
    fpu_pkg::fp_rm_t        i_rm;
    logic                   i_flags_clr;
    logic                   o_valid;
    fpu_pkg::fp32_t         o_result;
    fpu_pkg::fp_flags_t     o_flags;
    fpu_pkg::fp_flags_t     o_fflags;
    logic                   o_audit_err;
    int                     mismatch_cnt;
    int                     fail_cnt;
    int                     checked;
    int                     n_sent = 0;
    int                     gap;
    logic [31:0]            lfsr_state = 32'd50;
    logic [63:0]            pair;

    fp_mul_unit u_fp_mul_unit (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (i_valid),
        .i_a         (i_a),
        .i_b         (i_b),
        .i_rm        (i_rm),
        .i_flags_clr (i_flags_clr),
        .o_valid     (o_valid),
        .o_result    (o_result),
        .o_flags     (o_flags),
        .o_fflags    (o_fflags),
        .o_audit_err (o_audit_err)
    );

    fp_mul_checker u_checker (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_a            (i_a),
        .i_b            (i_b),
        .i_rm           (i_rm),
        .i_flags_clr    (i_flags_clr),
        .i_out_valid    (o_valid),
        .i_result       (o_result),
        .i_flags        (o_flags),
        .i_fflags       (o_fflags),
        .i_audit_err    (o_audit_err),
        .o_mismatch_cnt (mismatch_cnt),
        .o_fail_cnt     (fail_cnt),
        .o_checked      (checked)
    );

    // right-shifting galois form
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // exponents lean toward zero, all-ones, tiny and huge values
    function automatic fpu_pkg::fp32_t rand_operand();
        logic           sign;
        logic [2:0]     cat;
        logic [7:0]     ex;
        logic [22:0]    frac;
        sign = take_bits(1);
        cat  = take_bits(3);
        frac = take_bits(23);
        case (cat)
            3'd0:    ex = 8'h00;
            3'd1:    ex = 8'hff;
            3'd2:    ex = take_bits(4);
            3'd3:    ex = 8'hf0 | take_bits(4);
            default: ex = 8'h40 + take_bits(7);
        endcase
        if (take_bits(3) == 0)
            frac = '0;
        return {sign, ex, frac};
    endfunction

    function automatic logic [63:0] edge_pair(input int i);
        case (i)
            0:       return {32'h40400000, 32'h40000001};
            1:       return {32'h7f400000, 32'h7f400000};
            2:       return {32'hff400000, 32'h7f400000};
            3:       return {32'h7fc00000, 32'h3f800000};
            4:       return {32'h7f800001, 32'h3f800000};
            5:       return {32'h7f800000, 32'h00000000};
            6:       return {32'h7f800000, 32'hc0000000};
            7:       return {32'h00000000, 32'hc0400000};
            8:       return {32'h00800000, 32'h00000001};
            9:       return {32'h00800000, 32'h3f000000};
            10:      return {32'h00000003, 32'hbf000000};
            11:      return {32'h007fffff, 32'h3f800001};
            default: return {32'h3f800000, 32'h3f800000};
        endcase
    endfunction

    task automatic send_op(input fpu_pkg::fp32_t a, input fpu_pkg::fp32_t b,
                           input fpu_pkg::fp_rm_t rm);
        i_valid     <= 1'b1;
        i_a         <= a;
        i_b         <= b;
        i_rm        <= rm;
        i_flags_clr <= take_bits(4) == 0;
        n_sent++;
        @(posedge i_clk);
    endtask

    task automatic idle_cycle();
        i_valid     <= 1'b0;
        i_flags_clr <= take_bits(4) == 0;
        @(posedge i_clk);
    endtask

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    initial begin
        repeat (TIMEOUT) @(posedge i_clk);
        $display("timeout after %0d cycles with %0d of %0d results checked",
                 TIMEOUT, checked, n_sent);
        $display("Test failed");
        $finish;
    end

    initial begin
        i_rst       = 1'b1;
        i_valid     = 1'b0;
        i_a         = '0;
        i_b         = '0;
        i_rm        = 5'b00001;
        i_flags_clr = 1'b0;
        repeat (RST_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;
        // each edge pair runs once in every rounding mode
        for (int i = 0; i < N_PAIRS; i++) begin
            pair = edge_pair(i);
            for (int m = 0; m < 5; m++)
                send_op(pair[63:32], pair[31:0], 5'b00001 << m);
        end
        for (int i = 0; i < N_RAND; i++) begin
            send_op(rand_operand(), rand_operand(), 5'b00001 << (take_bits(3) % 5));
            gap = (take_bits(2) == 0) ? take_bits(1) + 1 : 0;
            repeat (gap) idle_cycle();
        end
        while (checked < n_sent)
            idle_cycle();
        repeat (4) idle_cycle();
        $display("results %0d of %0d, mismatches %0d, other errors %0d",
                 checked, n_sent, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/fpu_pkg.sv
logic/fp_operand_unpack.sv
logic/fp_mul_round.sv
logic/fp_flag_audit.sv
logic/fp_mul_unit.sv
verif/fp_mul_checker.sv
verif/tb_fp_mul_unit.sv
